//--- files.f
hw/icache_pkg.sv
hw/icache_blocks.sv
hw/icache_fetch_stage.sv
hw/icache_line_fill.sv
hw/icache_top.sv
bench/tb_clock.sv
bench/axil_mem_model.sv
bench/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

SOURCES := $(shell cat files.f)

.PHONY: run clean

# the run passes only when the testbench prints its pass line
run: obj_dir/Vicache_tb
	@out="$$(./obj_dir/Vicache_tb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

# rebuilt only when the file list or one of its sources changes
obj_dir/Vicache_tb: files.f $(SOURCES)
	verilator --binary --timing -j 0 --top-module icache_tb -f files.f

clean:
	rm -rf obj_dir

//--- bench/icache_tb.sv
// instruction cache testbench, random fetch traffic against a reference model
// of the tag store and the memory content rule

`timescale 1ns/100ps

module icache_tb;

    // a fill is four AR/R pairs, each given up to 16 cycles of memory delay
    localparam int fill_bound    = 4 * 2 * 16;
    localparam int request_total = 265;

    logic        aclk;
    logic        aresetn;
    logic        flush;
    logic        req_valid;
    logic        req_ready;
    logic [31:0] req_addr;
    logic        resp_valid;
    logic        resp_ready = 1'b0;
    logic [31:0] resp_data;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [2:0]  arprot;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        ar_stall = 1'b0;
    logic        r_stall = 1'b0;
    logic [31:0] stim_bits = '0;
    logic [31:0] lfsr_state = 32'hb3dc9f3a;

    // reference model, direct mapped tags and the expected traffic in order
    logic        model_valid [64];
    logic [21:0] model_tag [64];
    logic [31:0] exp_data [512];
    int          accept_cycle [512];
    logic [31:0] exp_ar [2048];
    int          data_wr = 0;
    int          resp_rd = 0;
    int          ar_wr = 0;
    int          ar_rd = 0;
    int          ar_base;
    int          cycle_count = 0;
    int          last_accept;
    logic        read_open = 1'b0;
    logic [31:0] generation;
    logic        timing_mode;
    logic        hold_resp_ready;
    string       test_name;

    tb_clock tb_clock_inst (.aclk(aclk));

    axil_mem_model axil_mem_model_inst (
        .aclk(aclk), .aresetn(aresetn), .gen(generation),
        .ar_stall(ar_stall), .r_stall(r_stall),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
    );

    icache_top icache_top_inst (
        .aclk(aclk), .aresetn(aresetn), .flush(flush),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_data(resp_data),
        .arvalid(arvalid), .arready(arready), .araddr(araddr), .arprot(arprot),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
    );

    ////////////////////
    // helpers
    ////////////////////

    // Galois LFSR stepped once per bit, bits enter from the low end
    function logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return value;
    endfunction

    // memory content rule, the word a fill must bring back
    function automatic logic [31:0] expected_word(input logic [31:0] addr, input logic [31:0] g);
        return ({addr[15:0], addr[31:16]} ^ (addr * 32'h2545f491)) ^ g;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("Error in %s: expected 0x%08h, actual 0x%08h",
                                        name, expected, actual));
        end
    endtask

    // present one address, wait for its accepting edge, then predict hit or miss
    task automatic send_request(input logic [31:0] addr);
        logic [5:0]  index;
        logic [21:0] tag;
        logic        is_miss;
        index = addr[9:4];
        tag   = addr[31:10];
        @(negedge aclk);
        req_valid <= 1'b1;
        req_addr  <= addr;
        @(posedge aclk);
        while (!req_ready) begin
            @(posedge aclk);
        end
        is_miss = !(model_valid[index] && model_tag[index] == tag);
        if (is_miss) begin
            model_valid[index] = 1'b1;
            model_tag[index]   = tag;
            // a miss reads the whole line, word 0 first
            for (int i = 0; i < 4; i++) begin
                exp_ar[ar_wr] = {addr[31:4], 4'b0000} + 32'(4 * i);
                ar_wr++;
            end
        end
        exp_data[data_wr]     = expected_word(addr, generation);
        accept_cycle[data_wr] = cycle_count;
        data_wr++;
        last_accept = cycle_count;
    endtask

    // drop req_valid and wait until every accepted request has its response
    task automatic drain();
        @(negedge aclk);
        req_valid <= 1'b0;
        while (resp_rd != data_wr) begin
            @(posedge aclk);
        end
    endtask

    task automatic flush_cache();
        @(negedge aclk);
        flush <= 1'b1;
        @(posedge aclk);
        check_value("flush req_ready", 32'd0, {31'd0, req_ready});
        @(negedge aclk);
        flush <= 1'b0;
        @(posedge aclk);
        // memory changes with the generation, the model forgets every line
        generation = generation + 1;
        for (int i = 0; i < 64; i++) begin
            model_valid[i] = 1'b0;
        end
    endtask

    ////////////////////
    // per-cycle activity
    ////////////////////

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
    end

    // back-pressure, memory delays and stimulus bits, all from the one LFSR
    always @(negedge aclk) begin
        resp_ready <= hold_resp_ready | (random_bits(2) != 32'd0);
        ar_stall   <= (random_bits(2) == 32'd0);
        r_stall    <= (random_bits(2) == 32'd0);
        stim_bits  <= random_bits(16);
    end

    // responses must follow the model queue in request order
    always @(posedge aclk) begin
        if (resp_valid && resp_ready) begin
            if (resp_rd == data_wr) begin
                stop_with_failure("a response arrived with no request outstanding");
            end else begin
                check_value(test_name, exp_data[resp_rd], resp_data);
                if (timing_mode) begin
                    check_value("hit latency", accept_cycle[resp_rd] + 3, cycle_count);
                end
                resp_rd <= resp_rd + 1;
            end
        end
    end

    // every AR must belong to a predicted miss, at the line base plus 0, 4, 8, 12
    always @(posedge aclk) begin
        if (arvalid && arready) begin
            if (ar_rd == ar_wr) begin
                stop_with_failure("the cache read memory although no miss was predicted");
            end else begin
                check_value("AR address", exp_ar[ar_rd], araddr);
                check_value("AR protection", 32'h4, {29'd0, arprot});
                ar_rd <= ar_rd + 1;
            end
        end
    end

    // rready stays high from the AR handshake until the R beat arrives
    always @(posedge aclk) begin
        if (read_open) begin
            check_value("rready while a read is open", 32'd1, {31'd0, rready});
        end
        if (arvalid && arready) begin
            read_open <= 1'b1;
        end else if (rvalid && rready) begin
            read_open <= 1'b0;
        end
    end

    initial begin
        repeat (request_total * (fill_bound + 10) + 100) @(posedge aclk);
        stop_with_failure("Timeout, the cache stopped answering requests");
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        aresetn         = 1'b0;
        flush           = 1'b0;
        req_valid       = 1'b0;
        req_addr        = '0;
        generation      = '0;
        timing_mode     = 1'b0;
        hold_resp_ready = 1'b0;
        test_name       = "reset";
        for (int i = 0; i < 64; i++) begin
            model_valid[i] = 1'b0;
        end
        repeat (8) begin
            @(posedge aclk);
            check_value("reset outputs", 32'd0, {29'd0, req_ready, resp_valid, arvalid});
        end
        @(negedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
        check_value("req_ready at release", 32'd0, {31'd0, req_ready});
        @(posedge aclk);
        check_value("req_ready after release", 32'd1, {31'd0, req_ready});

        // one word out of each of twelve fresh lines
        test_name = "cold miss";
        ar_base   = ar_rd;
        for (int i = 0; i < 12; i++) begin
            send_request(32'h4000 + 32'(16 * i + 4 * (i % 4)));
        end
        drain();
        check_value("cold miss AR count", 32'd48, 32'(ar_rd - ar_base));

        test_name = "resident hit";
        for (int i = 0; i < 24; i++) begin
            send_request(32'h4000 + 32'(16 * (i % 12)) + {28'd0, stim_bits[10:9], 2'b00});
        end
        drain();

        // two tags fight over index 0x25
        test_name = "conflict eviction";
        ar_base   = ar_rd;
        for (int i = 0; i < 8; i++) begin
            send_request({(i % 2 == 0) ? 22'h155 : 22'h2aa, 6'h25, 2'(i), 2'b00});
        end
        drain();
        // every access of the pair evicts the other tag and reads a whole line
        check_value("conflict AR count", 32'd32, 32'(ar_rd - ar_base));

        // four tags over eight indices with random gaps and stalls
        test_name = "random traffic";
        for (int i = 0; i < 200; i++) begin
            send_request({20'h000c0, stim_bits[15:14], 3'b101, stim_bits[13:11],
                          stim_bits[10:9], 2'b00});
            if (stim_bits[1:0] == 2'b00) begin
                @(negedge aclk);
                req_valid <= 1'b0;
                repeat (stim_bits[3:2]) @(posedge aclk);
            end
        end
        drain();

        flush_cache();
        test_name = "flush refill";
        ar_base   = ar_rd;
        for (int i = 0; i < 12; i++) begin
            send_request(32'h4000 + 32'(16 * i + 4 * (i % 4)));
        end
        drain();
        // each of the twelve lines was resident before the flush and is read again
        check_value("flush refill AR count", 32'd48, 32'(ar_rd - ar_base));

        // warm one line, then stream hits with the fetch unit always ready
        test_name = "hit timing";
        hold_resp_ready = 1'b1;
        send_request(32'h8000);
        drain();
        timing_mode = 1'b1;
        for (int i = 0; i < 8; i++) begin
            send_request(32'h8000 + 32'(4 * (i % 4)));
            if (i != 0) begin
                check_value("back-to-back accept", accept_cycle[data_wr - 2] + 1, last_accept);
            end
        end
        drain();
        timing_mode = 1'b0;

        if (ar_rd == ar_wr && resp_rd == data_wr) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_with_failure("memory reads or responses were missing at the end of the run");
        end
    end

endmodule

//--- bench/axil_mem_model.sv
// AXI4-Lite read responder for the testbench, one read at a time with random delays
// every word follows the content rule of address and flush generation

`timescale 1ns/100ps

module axil_mem_model (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [31:0] gen,
    input  logic        ar_stall,
    input  logic        r_stall,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    logic        read_pending;
    logic [31:0] read_addr;

    // fixed mix of the address, XOR the generation counter
    function automatic logic [31:0] mem_word(input logic [31:0] addr, input logic [31:0] g);
        return ({addr[15:0], addr[31:16]} ^ (addr * 32'h2545f491)) ^ g;
    endfunction

    // handshakes complete on the rising edge
    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            read_pending <= 1'b0;
            read_addr    <= '0;
        end else if (arvalid && arready) begin
            read_pending <= 1'b1;
            read_addr    <= araddr;
        end else if (rvalid && rready) begin
            read_pending <= 1'b0;
        end
    end

    // responses move on the falling edge, rvalid stays up once raised
    always @(negedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= 2'b00;
        end else begin
            arready <= !read_pending && !ar_stall;
            rvalid  <= read_pending && (rvalid || !r_stall);
            rdata   <= mem_word(read_addr, gen);
            rresp   <= 2'b00;
        end
    end

endmodule

//--- bench/tb_clock.sv
// testbench clock source, 8 ns period

`timescale 1ns/100ps

module tb_clock (
    output logic aclk
);

    // starts low, first rising edge at 4 ns
    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

endmodule

//--- hw/icache_top.sv
// icache top level, direct-mapped instruction cache with an AXI4-Lite read port
// ties the fetch pipeline, the block store and the line fill engine together

`timescale 1ns/100ps

module icache_top (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          flush,
    // fetch requests
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic [icache_pkg::addr_w-1:0] req_addr,
    // instructions back to the fetch unit, in request order
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic [icache_pkg::ilen-1:0]   resp_data,
    // AXI4-Lite read address channel
    output logic                          arvalid,
    input  logic                          arready,
    output logic [icache_pkg::addr_w-1:0] araddr,
    output logic [2:0]                    arprot,
    // AXI4-Lite read data channel
    input  logic                          rvalid,
    output logic                          rready,
    input  logic [icache_pkg::ilen-1:0]   rdata,
    input  logic [1:0]                    rresp
);

    import icache_pkg::*;

    ////////////////////
    // internal wiring
    ////////////////////

    // lookup port, fetch stage to block store
    logic              lookup_ren;
    icache_addr_u      lookup_addr;
    logic              lookup_hit;
    logic              lookup_miss;
    logic [ilen-1:0]   lookup_rdata;

    // fill request and completion
    logic              fill_req;
    icache_addr_u      fill_addr;
    logic              fill_done;

    // line write, fill engine to block store
    logic              line_wen;
    icache_addr_u      line_waddr;
    logic [line_w-1:0] line_wdata;

    icache_fetch_stage icache_fetch_stage_inst (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_ready (resp_ready),
        .flush      (flush),
        .ren        (lookup_ren),
        .raddr      (lookup_addr),
        .hit        (lookup_hit),
        .miss       (lookup_miss),
        .rdata      (lookup_rdata),
        .fill_req   (fill_req),
        .fill_addr  (fill_addr),
        .fill_done  (fill_done)
    );

    icache_blocks icache_blocks_inst (
        .aclk    (aclk),
        .aresetn (aresetn),
        .flush   (flush),
        .wen     (line_wen),
        .waddr   (line_waddr),
        .wdata   (line_wdata),
        .ren     (lookup_ren),
        .raddr   (lookup_addr),
        .rdata   (lookup_rdata),
        .hit     (lookup_hit),
        .miss    (lookup_miss)
    );

    icache_line_fill icache_line_fill_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .fill_req  (fill_req),
        .fill_addr (fill_addr),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .arprot    (arprot),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .wen       (line_wen),
        .waddr     (line_waddr),
        .wdata     (line_wdata),
        .fill_done (fill_done)
    );

endmodule

//--- hw/icache_line_fill.sv
// icache line fill engine, reads four words over AXI4-Lite one at a time
// and writes the assembled 128-bit line into the block store

`timescale 1ns/100ps

module icache_line_fill (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          fill_req,
    input  icache_pkg::icache_addr_u      fill_addr,
    output logic                          arvalid,
    input  logic                          arready,
    output logic [icache_pkg::addr_w-1:0] araddr,
    output logic [2:0]                    arprot,
    input  logic                          rvalid,
    output logic                          rready,
    input  logic [icache_pkg::ilen-1:0]   rdata,
    input  logic [1:0]                    rresp,
    output logic                          wen,
    output icache_pkg::icache_addr_u      waddr,
    output logic [icache_pkg::line_w-1:0] wdata,
    output logic                          fill_done
);

    import icache_pkg::*;

    ////////////////////
    // declarations
    ////////////////////

    // one word per AR/R pair, then a write cycle and a done cycle
    typedef enum logic [2:0] {
        st_idle,
        st_ar,
        st_r,
        st_write,
        st_done
    } fill_state_t;

    fill_state_t state;

    // word counter inside the line
    logic [offset_w-1:0] beat;

    // line base address and the line being assembled
    icache_addr_u        line_addr;
    logic [line_w-1:0]   line_q;

    // address of the current beat
    icache_addr_u        ar_addr;

    ////////////////////
    // AXI4-Lite read channels
    ////////////////////

    // unprivileged, secure, instruction access
    assign arprot = 3'b100;

    // the beat address is the line base with the word offset set to the counter
    always_comb begin
        ar_addr            = line_addr;
        ar_addr.f.offset   = beat;
        ar_addr.f.byte_off = 2'b00;
    end

    assign araddr = ar_addr.raw;

    // arvalid holds the address until arready, rready waits for the single R beat
    assign arvalid = (state == st_ar);
    assign rready  = (state == st_r);

    ////////////////////
    // block store side
    ////////////////////

    // the line goes into the store in one cycle, fill_done follows a cycle later
    assign wen       = (state == st_write);
    assign waddr     = line_addr;
    assign wdata     = line_q;
    assign fill_done = (state == st_done);

    ////////////////////
    // fill FSM
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= st_idle;
            beat  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (fill_req) begin
                        beat  <= '0;
                        state <= st_ar;
                    end
                end
                st_ar: begin
                    if (arready) begin
                        state <= st_r;
                    end
                end
                st_r: begin
                    // rresp is not checked, an error word is stored as returned
                    if (rvalid) begin
                        if (beat == offset_w'(words_per_line - 1)) begin
                            state <= st_write;
                        end else begin
                            beat  <= beat + 1'b1;
                            state <= st_ar;
                        end
                    end
                end
                st_write: begin
                    state <= st_done;
                end
                st_done: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // base address taken when the fill starts, fill_addr stays stable anyway
    always_ff @(posedge aclk) begin
        if (state == st_idle && fill_req) begin
            line_addr            <= fill_addr;
            line_addr.f.offset   <= '0;
            line_addr.f.byte_off <= 2'b00;
        end
    end

    // each word enters at the top and shifts down, after four beats
    // word 0 ends up in the low bits
    always_ff @(posedge aclk) begin
        if (state == st_r && rvalid) begin
            line_q <= {rdata, line_q[line_w-1:ilen]};
        end
    end

endmodule

//--- hw/icache_fetch_stage.sv
// icache fetch pipeline, request acceptance, lookup stage and response register
// a miss stalls the lookup stage, requests a line fill and replays the lookup

`timescale 1ns/100ps

module icache_fetch_stage (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          req_valid,
    input  logic [icache_pkg::addr_w-1:0] req_addr,
    output logic                          req_ready,
    output logic                          resp_valid,
    output logic [icache_pkg::ilen-1:0]   resp_data,
    input  logic                          resp_ready,
    input  logic                          flush,
    output logic                          ren,
    output icache_pkg::icache_addr_u      raddr,
    input  logic                          hit,
    input  logic                          miss,
    input  logic [icache_pkg::ilen-1:0]   rdata,
    output logic                          fill_req,
    output icache_pkg::icache_addr_u      fill_addr,
    input  logic                          fill_done
);

    import icache_pkg::*;

    // goes high the first edge after reset release, opens the request port
    logic         run;

    // acceptance register, holds the address presented to the block store
    logic         acc_valid;
    icache_addr_u acc_addr;

    // lookup stage, its result sits in the hit/miss/rdata registers of the blocks
    logic         lk_valid;
    logic         lk_wait;
    icache_addr_u lk_addr;

    logic         accept;
    logic         resp_stall;
    logic         lk_live;
    logic         lk_move;
    logic         lk_miss;
    logic         advance;
    logic         replay;

    ////////////////////
    // stage control
    ////////////////////

    assign accept = req_valid & req_ready;

    // the response register cannot take a new word
    assign resp_stall = resp_valid & ~resp_ready;

    // the block outputs belong to the lookup stage unless a fill is pending
    assign lk_live = lk_valid & ~lk_wait;
    assign lk_move = lk_live & hit & ~resp_stall;
    assign lk_miss = lk_live & miss;

    // the acceptance register moves into lookup only when lookup drains
    // and nothing waits in a stalled response register
    assign advance = acc_valid & ~resp_stall & (~lk_valid | lk_move);

    // once the line is in the store the held address is looked up again
    assign replay = lk_wait & fill_done;

    // lookup and replay never overlap, lk_wait keeps the lookup stage full
    assign ren   = advance | replay;
    assign raddr = lk_wait ? lk_addr : acc_addr;

    // one cycle request, lk_wait rises on the next edge and ends the pulse
    assign fill_req  = lk_miss;
    assign fill_addr = lk_addr;

    // closed during flush, back-pressure and the whole miss window
    assign req_ready = run & ~flush & ~resp_stall & ~lk_wait & ~lk_miss &
                       (~acc_valid | advance);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    ////////////////////
    // acceptance register
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            acc_valid <= 1'b0;
        end else if (accept) begin
            acc_valid <= 1'b1;
        end else if (advance) begin
            acc_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            acc_addr.raw <= req_addr;
        end
    end

    ////////////////////
    // lookup stage
    ////////////////////

    // lk_wait marks the miss-pending state, set by the miss and cleared by the replay
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lk_valid <= 1'b0;
            lk_wait  <= 1'b0;
        end else begin
            if (advance) begin
                lk_valid <= 1'b1;
            end else if (lk_move) begin
                lk_valid <= 1'b0;
            end
            if (lk_miss) begin
                lk_wait <= 1'b1;
            end else if (replay) begin
                lk_wait <= 1'b0;
            end
        end
    end

    // kept for the fill and the replay while the stage is stalled
    always_ff @(posedge aclk) begin
        if (advance) begin
            lk_addr <= acc_addr;
        end
    end

    ////////////////////
    // response register
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            resp_valid <= 1'b0;
        end else if (lk_move) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // the word stays put until the fetch unit takes it
    always_ff @(posedge aclk) begin
        if (lk_move) begin
            resp_data <= rdata;
        end
    end

endmodule

//--- hw/icache_blocks.sv
// icache block store, direct mapped data and tag arrays with valid bits
// lookup registers hit, miss and the addressed instruction word

`timescale 1ns/100ps

module icache_blocks (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          flush,
    input  logic                          wen,
    input  icache_pkg::icache_addr_u      waddr,
    input  logic [icache_pkg::line_w-1:0] wdata,
    input  logic                          ren,
    input  icache_pkg::icache_addr_u      raddr,
    output logic [icache_pkg::ilen-1:0]   rdata,
    output logic                          hit,
    output logic                          miss
);

    import icache_pkg::*;

    ////////////////////
    // storage
    ////////////////////

    // line payload and tag per index, both written together by a fill
    logic [line_w-1:0] data_mem [cache_depth];
    logic [tag_w-1:0]  tag_mem  [cache_depth];

    // one valid bit per line, the only part of the store that is reset
    logic [cache_depth-1:0] valid_bits;

    // line and tag selected by the lookup address
    logic [line_w-1:0] rline;
    logic [tag_w-1:0]  rtag;
    logic              rset;
    logic              tag_match;

    ////////////////////
    // line write
    ////////////////////

    // a fill writes the whole assembled line at the index of waddr
    always_ff @(posedge aclk) begin
        if (wen) begin
            data_mem[waddr.f.index] <= wdata;
            tag_mem[waddr.f.index]  <= waddr.f.tag;
        end
    end

    // flush (FENCE.i) drops every line at once
    // a write in the same cycle still marks its own line as present,
    // since the second assignment wins
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_bits <= '0;
        end else begin
            if (flush) begin
                valid_bits <= '0;
            end
            if (wen) begin
                valid_bits[waddr.f.index] <= 1'b1;
            end
        end
    end

    ////////////////////
    // lookup
    ////////////////////

    // the arrays are read asynchronously, the result is captured below
    assign rline = data_mem[raddr.f.index];
    assign rtag  = tag_mem[raddr.f.index];
    assign rset  = valid_bits[raddr.f.index];

    // a line only counts when it has been filled since the last flush
    assign tag_match = rset && (rtag == raddr.f.tag);

    // hit and miss are control state, so they start cleared
    // both hold while ren is low so the fetch stage can stall on them
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end else if (ren) begin
            hit  <= tag_match;
            miss <= ~tag_match;
        end
    end

    // pick the instruction of the line by its word offset, word 0 in the low bits
    always_ff @(posedge aclk) begin
        if (ren) begin
            rdata <= rline[raddr.f.offset*ilen +: ilen];
        end
    end

endmodule

//--- hw/icache_pkg.sv
// icache package with the cache geometry and the fetch address layout
// shared by the fetch stage, the block store and the line fill engine

package icache_pkg;

    ////////////////////
    // geometry
    ////////////////////

    // byte address width of the fetch path and the AXI4-Lite bus
    localparam int addr_w = 32;

    // instruction width, 32 bits whatever the architecture
    localparam int ilen = 32;

    // payload of one cache line, four instructions
    localparam int line_w = 128;
    localparam int words_per_line = line_w / ilen;

    // word offset inside a line
    localparam int offset_w = $clog2(words_per_line);

    // number of lines in the direct-mapped store
    localparam int cache_depth = 64;
    localparam int index_w = $clog2(cache_depth);

    // the tag keeps what is left once index, offset and the two byte bits are taken
    localparam int tag_w = addr_w - index_w - offset_w - 2;

    ////////////////////
    // address layout
    ////////////////////

    // a fetch address is carried as a raw bus word (request port, araddr)
    // and decoded in place into its cache fields
    //
    //   | tag | index | offset | byte_off |
    //
    // the byte bits are always zero for word aligned instruction fetches
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] offset;
            logic [1:0]          byte_off;
        } f;
    } icache_addr_u;

endpackage
